//--- rtl/matcalc_pkg.sv
`default_nettype none

package matcalc_pkg;

    localparam int MAX_DIM   = 5;
    localparam int MAX_ELEMS = 25;
    localparam int NUM_SLOTS = 8;

    typedef logic [15:0] elem_t;   // wraps mod 2^16
    typedef logic [2:0]  dim_t;
    typedef logic [2:0]  slot_t;

    // row-major, only rows*cols entries meaningful
    typedef struct packed {
        dim_t                        rows;
        dim_t                        cols;
        elem_t [MAX_ELEMS-1:0]       data;
    } matrix_t;

    typedef enum logic [1:0] {
        OP_TRANS = 2'd0,
        OP_ADD   = 2'd1,
        OP_SCALE = 2'd2,
        OP_MULT  = 2'd3
    } op_e;

    typedef enum logic [7:0] {
        CMD_LOAD = 8'h01,
        CMD_OP   = 8'h02
    } cmd_e;

    typedef struct packed {
        op_e     op;
        matrix_t a;
        matrix_t b;
        elem_t   scalar;
    } op_req_t;

    typedef struct packed {
        logic       is_matrix;
        logic [7:0] code;
        matrix_t    mat;
    } print_req_t;

    localparam logic [7:0] REPLY_ACK  = 8'h06;
    localparam logic [7:0] REPLY_ERR  = 8'h15;
    localparam logic [7:0] RESULT_HDR = 8'hA5;

endpackage

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115200
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    localparam int BIT_CYC = CLK_FREQ / BAUD_RATE;
    localparam int CW      = $clog2(BIT_CYC + 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    rx_sync;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            rx_sync    <= 2'b11;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_data  <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], rx};
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == BIT_CYC / 2 - 1) begin   // middle of start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;  // glitch goes back
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_CYC - 1) begin
                        cnt       <= '0;
                        byte_data <= {rx_sync[1], byte_data[7:1]};  // lsb first
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == BIT_CYC - 1) begin
                        byte_valid <= rx_sync[1];   // drop on framing error
                        state      <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115200
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       credit,
    output logic       tx
);
    localparam int BIT_CYC = CLK_FREQ / BAUD_RATE;
    localparam int CW      = $clog2(BIT_CYC + 1);

    logic [7:0]    hold_byte;
    logic          hold_full;
    logic [9:0]    shreg;       // stop, data, start
    logic [3:0]    bits_left;
    logic [CW-1:0] cnt;

    assign tx = shreg[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_byte <= '0;
            hold_full <= 1'b0;
            shreg     <= '1;
            bits_left <= '0;
            cnt       <= '0;
            credit    <= 1'b0;
        end else begin
            credit <= 1'b0;
            if (tx_valid) begin
                hold_byte <= tx_byte;
                hold_full <= 1'b1;
            end
            if (bits_left == 4'd0) begin
                if (hold_full) begin
                    shreg     <= {1'b1, hold_byte, 1'b0};
                    bits_left <= 4'd10;
                    cnt       <= '0;
                    hold_full <= 1'b0;
                    credit    <= 1'b1;  // slot free again
                end
            end else if (cnt == BIT_CYC - 1) begin
                cnt       <= '0;
                shreg     <= {1'b1, shreg[9:1]};
                bits_left <= bits_left - 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // sender must respect the single credit
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid |-> !hold_full);

endmodule

`default_nettype wire

//--- rtl/matrix_store.sv
`timescale 1ns/10ps
`default_nettype none

module matrix_store
    import matcalc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_en,
    input  slot_t   wr_slot,
    input  matrix_t wr_mat,
    input  slot_t   rd_slot_a,
    input  slot_t   rd_slot_b,
    output matrix_t rd_a,
    output matrix_t rd_b
);
    matrix_t slots [NUM_SLOTS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '{rows: dim_t'(1), cols: dim_t'(1), data: '0};  // 1x1 zero
            end
        end else if (wr_en) begin
            slots[wr_slot] <= wr_mat;
        end
    end

    assign rd_a = slots[rd_slot_a];
    assign rd_b = slots[rd_slot_b];

    // dimension checks live in the parser
    a_dims_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_mat.rows inside {[1:MAX_DIM]} && wr_mat.cols inside {[1:MAX_DIM]}));

endmodule

`default_nettype wire

//--- rtl/matrix_alu.sv
`timescale 1ns/10ps
`default_nettype none

module matrix_alu
    import matcalc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  op_req_t req,
    output logic    done,
    output matrix_t result
);
    op_req_t mreq;      // operands held for multiply
    logic    mult_busy;
    dim_t    row;
    dim_t    col;
    matrix_t quick;
    elem_t   dot;

    // single step ops
    always_comb begin
        quick      = '0;
        quick.rows = req.a.rows;
        quick.cols = req.a.cols;
        case (req.op)
            OP_TRANS: begin
                quick.rows = req.a.cols;
                quick.cols = req.a.rows;
                for (int i = 0; i < MAX_DIM; i++) begin
                    for (int j = 0; j < MAX_DIM; j++) begin
                        if (i < req.a.rows && j < req.a.cols) begin
                            quick.data[j * req.a.rows + i] = req.a.data[i * req.a.cols + j];
                        end
                    end
                end
            end
            OP_ADD: begin
                for (int k = 0; k < MAX_ELEMS; k++) begin
                    quick.data[k] = req.a.data[k] + req.b.data[k];
                end
            end
            OP_SCALE: begin
                for (int k = 0; k < MAX_ELEMS; k++) begin
                    quick.data[k] = req.a.data[k] * req.scalar;
                end
            end
            default: ;  // multiply runs sequentially
        endcase
    end

    // dot product for result element (row, col)
    always_comb begin
        dot = '0;
        for (int k = 0; k < MAX_DIM; k++) begin
            if (k < mreq.a.cols) begin
                dot = dot + mreq.a.data[row * mreq.a.cols + k] * mreq.b.data[k * mreq.b.cols + col];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done      <= 1'b0;
            mult_busy <= 1'b0;
            row       <= '0;
            col       <= '0;
            result    <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                row <= '0;
                col <= '0;
                if (req.op == OP_MULT) begin
                    mult_busy <= 1'b1;
                    result    <= '{rows: req.a.rows, cols: req.b.cols, data: '0};
                end else begin
                    result <= quick;
                    done   <= 1'b1;
                end
            end else if (mult_busy) begin
                result.data[int'(row) * mreq.b.cols + col] <= dot;
                if (col == mreq.b.cols - 1'b1) begin
                    col <= '0;
                    if (row == mreq.a.rows - 1'b1) begin
                        mult_busy <= 1'b0;
                        done      <= 1'b1;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mreq <= req;
        end
    end

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !mult_busy);

endmodule

`default_nettype wire

//--- rtl/command_parser.sv
`timescale 1ns/10ps
`default_nettype none

module command_parser
    import matcalc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic       wr_en,
    output slot_t      wr_slot,
    output matrix_t    wr_mat,
    output slot_t      rd_slot_a,
    output slot_t      rd_slot_b,
    input  matrix_t    rd_a,
    input  matrix_t    rd_b,
    output logic       start,
    output op_req_t    op_req,
    input  logic       done,
    input  matrix_t    result,
    output logic       print_valid,
    output print_req_t print_req,
    input  logic       print_busy,
    output logic       led_error
);
    localparam print_req_t ERR_REQ = '{is_matrix: 1'b0, code: REPLY_ERR, mat: '0};
    localparam print_req_t ACK_REQ = '{is_matrix: 1'b0, code: REPLY_ACK, mat: '0};

    typedef enum logic [2:0] {IDLE, LOAD_HDR, LOAD_DATA, OP_HDR, RUN, REPLY} state_e;

    state_e      state;
    logic [1:0]  hdr_cnt;
    logic        bad;       // frame already known to fail
    logic [7:0]  rows_b;
    logic [15:0] total;     // element bytes still owed by the host
    logic [15:0] idx;
    op_e         op;
    logic        dims_bad;

    assign dims_bad = bad
        || (op == OP_ADD && (rd_a.rows != rd_b.rows || rd_a.cols != rd_b.cols))
        || (op == OP_MULT && rd_a.cols != rd_b.rows);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            hdr_cnt     <= '0;
            bad         <= 1'b0;
            rows_b      <= '0;
            total       <= '0;
            idx         <= '0;
            op          <= OP_TRANS;
            wr_en       <= 1'b0;
            wr_slot     <= '0;
            wr_mat      <= '0;
            rd_slot_a   <= '0;
            rd_slot_b   <= '0;
            start       <= 1'b0;
            op_req      <= '0;
            print_valid <= 1'b0;
            print_req   <= '0;
            led_error   <= 1'b0;
        end else begin
            wr_en       <= 1'b0;
            start       <= 1'b0;
            print_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (byte_valid) begin
                        hdr_cnt <= '0;
                        bad     <= 1'b0;
                        if (byte_data == CMD_LOAD) begin
                            led_error   <= 1'b0;
                            wr_mat.data <= '0;
                            state       <= LOAD_HDR;
                        end else if (byte_data == CMD_OP) begin
                            led_error <= 1'b0;
                            state     <= OP_HDR;
                        end
                    end
                end
                LOAD_HDR: begin
                    if (byte_valid) begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        case (hdr_cnt)
                            2'd0: begin
                                wr_slot <= byte_data[2:0];
                                bad     <= byte_data >= NUM_SLOTS;
                            end
                            2'd1: begin
                                rows_b      <= byte_data;
                                wr_mat.rows <= byte_data[2:0];
                                if (byte_data == 8'd0 || byte_data > MAX_DIM) begin
                                    bad <= 1'b1;
                                end
                            end
                            default: begin
                                wr_mat.cols <= byte_data[2:0];
                                total       <= rows_b * byte_data;
                                idx         <= '0;
                                if (byte_data == 8'd0 || byte_data > MAX_DIM) begin
                                    bad <= 1'b1;
                                end
                                if (rows_b == 8'd0 || byte_data == 8'd0) begin
                                    print_req <= ERR_REQ;   // no element bytes follow
                                    led_error <= 1'b1;
                                    state     <= REPLY;
                                end else begin
                                    state <= LOAD_DATA;
                                end
                            end
                        endcase
                    end
                end
                LOAD_DATA: begin
                    if (byte_valid) begin
                        if (idx < MAX_ELEMS) begin
                            wr_mat.data[idx] <= {8'h00, byte_data};
                        end
                        idx <= idx + 16'd1;
                        if (idx + 16'd1 == total) begin
                            state <= REPLY;
                            if (bad) begin
                                print_req <= ERR_REQ;
                                led_error <= 1'b1;
                            end else begin
                                wr_en     <= 1'b1;
                                print_req <= ACK_REQ;
                            end
                        end
                    end
                end
                OP_HDR: begin
                    if (byte_valid) begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        case (hdr_cnt)
                            2'd0: begin
                                op  <= op_e'(byte_data[1:0]);
                                bad <= byte_data > 8'd3;
                            end
                            2'd1: rd_slot_a <= byte_data[2:0];
                            2'd2: rd_slot_b <= byte_data[2:0];
                            default: begin
                                // store reads are combinational, operands valid here
                                if (dims_bad) begin
                                    print_req <= ERR_REQ;
                                    led_error <= 1'b1;
                                    state     <= REPLY;
                                end else begin
                                    op_req <= '{op: op, a: rd_a, b: rd_b,
                                                scalar: {8'h00, byte_data}};
                                    start  <= 1'b1;
                                    state  <= RUN;
                                end
                            end
                        endcase
                    end
                end
                RUN: begin
                    if (done) begin
                        print_req <= '{is_matrix: 1'b1, code: RESULT_HDR, mat: result};
                        state     <= REPLY;
                    end
                end
                REPLY: begin
                    if (!print_busy) begin
                        print_valid <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/result_printer.sv
`timescale 1ns/10ps
`default_nettype none

module result_printer
    import matcalc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       print_valid,
    input  print_req_t print_req,
    output logic       print_busy,
    output logic       tx_valid,
    output logic [7:0] tx_byte,
    input  logic       credit
);
    print_req_t req;
    logic [5:0] idx;        // byte index, 53 bytes max
    logic [5:0] last;
    logic [4:0] el;
    logic [1:0] credits;

    assign last = req.is_matrix ? 6'(2 * req.mat.rows * req.mat.cols + 2) : 6'd0;
    assign el   = 5'((idx - 6'd3) >> 1);

    // header, rows, cols, then elements high byte first
    always_comb begin
        if (!req.is_matrix) begin
            tx_byte = req.code;
        end else begin
            case (idx)
                6'd0:    tx_byte = req.code;
                6'd1:    tx_byte = {5'd0, req.mat.rows};
                6'd2:    tx_byte = {5'd0, req.mat.cols};
                default: tx_byte = idx[0] ? req.mat.data[el][15:8] : req.mat.data[el][7:0];
            endcase
        end
    end

    assign tx_valid = print_busy && credits != 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            print_busy <= 1'b0;
            idx        <= '0;
            credits    <= 2'd1;     // tx holding register starts empty
        end else begin
            credits <= credits + {1'b0, credit} - {1'b0, tx_valid};
            if (print_valid && !print_busy) begin
                print_busy <= 1'b1;
                idx        <= '0;
            end else if (tx_valid) begin
                if (idx == last) begin
                    print_busy <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (print_valid && !print_busy) begin
            req <= print_req;
        end
    end

endmodule

`default_nettype wire

//--- rtl/matcalc_top.sv
`timescale 1ns/10ps
`default_nettype none

module matcalc_top
    import matcalc_pkg::*;
#(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 115200
) (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic uart_tx,
    output logic led_error
);
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       wr_en;
    slot_t      wr_slot;
    matrix_t    wr_mat;
    slot_t      rd_slot_a;
    slot_t      rd_slot_b;
    matrix_t    rd_a;
    matrix_t    rd_b;
    logic       alu_start;
    op_req_t    op_req;
    logic       alu_done;
    matrix_t    alu_result;
    logic       print_valid;
    print_req_t print_req;
    logic       print_busy;
    logic       tx_valid;
    logic [7:0] tx_byte;
    logic       tx_credit;

    uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
        .clk(clk), .rst_n(rst_n), .rx(uart_rx),
        .byte_data(rx_byte), .byte_valid(rx_valid)
    );

    matrix_store u_store (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_slot(wr_slot), .wr_mat(wr_mat),
        .rd_slot_a(rd_slot_a), .rd_slot_b(rd_slot_b), .rd_a(rd_a), .rd_b(rd_b)
    );

    matrix_alu u_alu (
        .clk(clk), .rst_n(rst_n), .start(alu_start), .req(op_req),
        .done(alu_done), .result(alu_result)
    );

    command_parser u_parser (
        .clk(clk), .rst_n(rst_n), .byte_data(rx_byte), .byte_valid(rx_valid),
        .wr_en(wr_en), .wr_slot(wr_slot), .wr_mat(wr_mat),
        .rd_slot_a(rd_slot_a), .rd_slot_b(rd_slot_b), .rd_a(rd_a), .rd_b(rd_b),
        .start(alu_start), .op_req(op_req), .done(alu_done), .result(alu_result),
        .print_valid(print_valid), .print_req(print_req), .print_busy(print_busy),
        .led_error(led_error)
    );

    result_printer u_printer (
        .clk(clk), .rst_n(rst_n), .print_valid(print_valid), .print_req(print_req),
        .print_busy(print_busy), .tx_valid(tx_valid), .tx_byte(tx_byte), .credit(tx_credit)
    );

    uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
        .clk(clk), .rst_n(rst_n), .tx_valid(tx_valid), .tx_byte(tx_byte),
        .credit(tx_credit), .tx(uart_tx)
    );

endmodule

`default_nettype wire

//--- test/tb_matcalc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_matcalc;
    localparam int BIT_CYC       = 8;       // 80 / 10
    localparam int START_TIMEOUT = 20000;   // cycles, long enough for a whole frame to go out
    localparam int RUN_LIMIT     = 500000;

    logic       clk;
    logic       rst_n;
    logic       rx_line;
    logic       tx_line;
    logic       led_error;

    logic [7:0] cmd_q[$];
    logic [7:0] exp_q[$];
    logic       exp_led;
    string      test_name;
    string      line;
    bit         have_test;
    int         test_errors;
    int         pass_count;
    int         fail_count;
    int         fd;
    int         seed;

    matcalc_top #(.CLK_FREQ(80), .BAUD_RATE(10)) uut (
        .clk(clk), .rst_n(rst_n), .uart_rx(rx_line), .uart_tx(tx_line),
        .led_error(led_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // last resort if something stalls outside the wait loops
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("timeout: simulation ran past %0d cycles", RUN_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        @(posedge clk);
        #1 rx_line = 1'b0;      // start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(posedge clk);
            #1 rx_line = b[i];
        end
        repeat (BIT_CYC) @(posedge clk);
        #1 rx_line = 1'b1;
        repeat (BIT_CYC) @(posedge clk);
        gap = $urandom % 4;     // idle bit times
        repeat (gap * BIT_CYC) @(posedge clk);
    endtask

    task automatic send_frame();
        foreach (cmd_q[i]) begin
            send_byte(cmd_q[i]);
        end
    endtask

    // line sampled on falling edges, away from the DUT's updates
    task automatic receive_byte(output logic [7:0] b, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        b  = '0;
        while (tx_line !== 1'b0 && n < START_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (tx_line === 1'b0) begin
            repeat (3) @(negedge clk);  // middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYC) @(negedge clk);
                b[i] = tx_line;
            end
            repeat (BIT_CYC) @(negedge clk);
            if (tx_line !== 1'b1) begin
                $display("framing error: stop bit on uart_tx is low");
                test_errors++;
            end
            ok = 1'b1;
        end
    endtask

    task automatic receive_reply();
        logic [7:0] b;
        bit         ok;
        ok = 1'b1;
        for (int k = 0; k < exp_q.size() && ok; k++) begin
            receive_byte(b, ok);
            if (ok) begin
                check_val($sformatf("uart_tx byte %0d", k), exp_q[k], b);
            end else begin
                $display("timeout: no start bit on uart_tx for reply byte %0d", k);
                test_errors++;
            end
        end
    endtask

    // name, command bytes | reply bytes | led_error
    task automatic parse_line(input string s, output bit valid);
        int    field;
        int    start;
        int    val;
        int    n;
        byte   c;
        string tok;
        valid   = 1'b0;
        field   = 0;
        start   = -1;
        exp_led = 1'b0;
        cmd_q.delete();
        exp_q.delete();
        if (s.len() > 0 && s.getc(0) != "#") begin
            for (int i = 0; i <= s.len(); i++) begin
                c = (i < s.len()) ? s.getc(i) : 8'h20;
                if (c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
                    if (start >= 0) begin
                        tok   = s.substr(start, i - 1);
                        start = -1;
                        if (!valid) begin
                            test_name = tok;
                            valid     = 1'b1;
                        end else if (tok == "|") begin
                            field++;
                        end else begin
                            val = 0;
                            n   = $sscanf(tok, "%h", val);
                            if (n != 1) begin
                                $display("golden file: bad token %s in test %s", tok, test_name);
                                test_errors++;
                            end
                            if (field == 0) begin
                                cmd_q.push_back(val[7:0]);
                            end else if (field == 1) begin
                                exp_q.push_back(val[7:0]);
                            end else begin
                                exp_led = val[0];
                            end
                        end
                    end
                end else if (start < 0) begin
                    start = i;
                end
            end
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            pass_count++;
        end else begin
            $display("FAIL %s (%0d errors)", test_name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    initial begin
        rx_line     = 1'b1;
        rst_n       = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        seed        = $urandom(86);
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        test_name = "reset";
        check_val("uart_tx", 32'd1, tx_line);
        check_val("led_error", 32'd0, led_error);
        report_test();

        fd = $fopen("test/matcalc_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open test/matcalc_golden.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    test_errors = 0;
                    parse_line(line, have_test);
                    if (have_test) begin
                        fork
                            send_frame();
                            receive_reply();
                        join
                        @(negedge clk);
                        check_val("led_error", exp_led, led_error);
                        report_test();
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/matcalc_golden.txt
# name  command bytes (hex) | expected reply bytes (hex) | led_error after reply
# earlier lines fill the slots that later lines read
load_a_2x3      01 00 02 03 01 02 03 04 05 06 | 06 | 0
load_b_3x2      01 01 03 02 07 08 09 0A 0B 0C | 06 | 0
trans_a         02 00 00 00 00 | A5 03 02 00 01 00 04 00 02 00 05 00 03 00 06 | 0
load_c_2x2      01 02 02 02 0A 14 1E 28 | 06 | 0
load_d_2x2      01 03 02 02 C8 FA FF 64 | 06 | 0
add_c_d         02 01 02 03 00 | A5 02 02 00 D2 01 0E 01 1D 00 8C | 0
scale_d_7       02 02 03 00 07 | A5 02 02 05 78 06 D6 06 F9 02 BC | 0
mult_a_b        02 03 00 01 00 | A5 02 02 00 3A 00 40 00 8B 00 9A | 0
add_mismatch    02 01 00 02 00 | 15 | 1
led_clear       02 00 02 00 00 | A5 02 02 00 0A 00 1E 00 14 00 28 | 0
load_bad_rows   01 04 06 01 01 02 03 04 05 06 | 15 | 1
load_after_bad  01 04 01 02 21 22 | 06 | 0
trans_e         02 00 04 00 00 | A5 02 01 00 21 00 22 | 0

//--- vlog.f
rtl/matcalc_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/matrix_store.sv
rtl/matrix_alu.sv
rtl/command_parser.sv
rtl/result_printer.sv
rtl/matcalc_top.sv
test/tb_matcalc.sv

//--- Bender.yml
package:
  name: matcalc

sources:
  - rtl/matcalc_pkg.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/matrix_store.sv
  - rtl/matrix_alu.sv
  - rtl/command_parser.sv
  - rtl/result_printer.sv
  - rtl/matcalc_top.sv
  - target: test
    files:
      - test/tb_matcalc.sv
